/* verilog.f */
+incdir+hdl
hdl/pd_pkg.sv
hdl/pd_byte_framer.sv
hdl/pd_controller.sv
hdl/pd_block_buffer.sv
hdl/pd_block_digest.sv
hdl/pd_top.sv
sim/pd_controller_sva.sv
sim/tb_pd_top.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_pd_top
FILELIST := verilog.f
BUILD    := obj_dir
RUN_ARGS := +verilator+error+limit+1000
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "FAIL: no verdict in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/tb_pd_top.sv */
// ##########################################################
// Testbench for pd_top: packet tasks, scenario sequence,
// reference digest fold and closing report
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

module tb_pd_top;
	timeunit 1ns;
	timeprecision 100ps;

	import pd_pkg::*;

	localparam int TIMEOUT   = 300;
	localparam int SEL_START = 0;
	localparam int SEL_EMPTY = 1;
	localparam int SEL_PERR  = 2;
	localparam int SEL_HERR  = 3;

	logic        clk;
	logic        n_rst;
	logic        rx_strobe;
	logic [7:0]  rx_byte;
	logic        rx_eop;
	logic        transmit_start;
	logic        transmit_empty;
	logic        p_error;
	logic        host_error;
	pd_err_e     last_error;
	logic        digest_ready;
	logic [31:0] digest;

	int          errors = 0;
	int          timeouts = 0;
	int          n_start = 0;
	int          n_empty = 0;
	int          n_perr = 0;
	int          n_herr = 0;
	// Block bytes in slot order
	logic [7:0]  blk [16];
	logic [7:0]  pkt_q [$];
	logic [31:0] held;

	pd_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Pulse counters sampled mid-cycle
	always @(negedge clk) begin
		if (transmit_start)
			n_start++;
		if (transmit_empty)
			n_empty++;
		if (p_error)
			n_perr++;
		if (host_error)
			n_herr++;
	end

	task automatic send_byte(input logic [7:0] data, input logic eop);
		@(negedge clk);
		rx_strobe = 1'b1;
		rx_byte   = data;
		rx_eop    = eop;
		@(negedge clk);
		rx_strobe = 1'b0;
		rx_eop    = 1'b0;
	endtask

	// PID first, then whatever sits in pkt_q
	task automatic send_packet(input logic [7:0] pid);
		send_byte(pid, pkt_q.size() == 0);
		foreach (pkt_q[i]) begin
			send_byte(pkt_q[i], i == pkt_q.size() - 1);
		end
		pkt_q.delete();
	endtask

	// HASH DATA0 carrying the first count bytes of blk
	task automatic send_first_half(input int count);
		send_packet(`PD_PID_OUT);
		pkt_q.push_back(`PD_TYPE_HASH);
		for (int i = 0; i < count; i++) begin
			pkt_q.push_back(blk[i]);
		end
		send_packet(`PD_PID_DATA0);
	endtask

	task automatic send_hash_block();
		send_first_half(`PD_PAYLOAD_BYTES);
		send_packet(`PD_PID_OUT);
		for (int i = `PD_PAYLOAD_BYTES; i < 2 * `PD_PAYLOAD_BYTES; i++) begin
			pkt_q.push_back(blk[i]);
		end
		send_packet(`PD_PID_DATA1);
	endtask

	task automatic new_block();
		foreach (blk[i]) begin
			blk[i] = 8'($urandom);
		end
	endtask

	// Seed, then XOR and rotate left for each big-endian word
	function automatic logic [31:0] fold_block();
		logic [31:0] d;
		logic [31:0] w;
		d = `PD_DIGEST_SEED;
		for (int i = 0; i < `PD_BLOCK_WORDS; i++) begin
			w = {blk[4*i], blk[4*i+1], blk[4*i+2], blk[4*i+3]};
			d = d ^ w;
			d = (d << `PD_DIGEST_ROT) | (d >> (32 - `PD_DIGEST_ROT));
		end
		return d;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Returns on a falling edge once the chosen counter reaches target
	task automatic await_pulse(input int sel, input int target, input string what);
		int seen;
		int t;
		seen = 0;
		for (t = 0; t < TIMEOUT; t++) begin
			@(posedge clk);
			case (sel)
				SEL_START: seen = n_start;
				SEL_EMPTY: seen = n_empty;
				SEL_PERR:  seen = n_perr;
				default:   seen = n_herr;
			endcase
			if (seen >= target)
				break;
		end
		if (t == TIMEOUT) begin
			$display("Timeout at %0t: %s pulse never came", $time, what);
			timeouts++;
		end
		@(negedge clk);
	endtask

	task automatic await_ready(input logic level);
		int t;
		t = 0;
		while (digest_ready !== level && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (t == TIMEOUT) begin
			$display("Timeout at %0t: digest_ready did not become %0b", $time, level);
			timeouts++;
		end
	endtask

	initial begin
		void'($urandom(74));
		n_rst     = 1'b0;
		rx_strobe = 1'b0;
		rx_byte   = 8'h00;
		rx_eop    = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;
		check_value(32'(digest_ready), 32'd0, "digest_ready after reset");
		check_value(32'(last_error), 32'(PD_ERR_NONE), "last_error after reset");

		// IN with nothing held
		send_packet(`PD_PID_IN);
		await_pulse(SEL_EMPTY, 1, "transmit_empty");
		check_value(n_start, 32'd0, "transmit_start count");

		// Full exchange, then IN collects the digest
		new_block();
		send_hash_block();
		await_ready(1'b1);
		check_value(digest, fold_block(), "digest");
		send_packet(`PD_PID_IN);
		await_pulse(SEL_START, 1, "transmit_start");
		check_value(32'(digest_ready), 32'd0, "digest_ready after IN");

		// Unknown PID, then DATA1 with no first half
		send_packet(8'hA5);
		await_pulse(SEL_PERR, 1, "p_error");
		check_value(32'(last_error), 32'(PD_ERR_PID), "last_error after bad PID");
		send_packet(`PD_PID_OUT);
		for (int i = 0; i < `PD_PAYLOAD_BYTES; i++) begin
			pkt_q.push_back(8'($urandom));
		end
		send_packet(`PD_PID_DATA1);
		await_pulse(SEL_PERR, 2, "p_error");
		check_value(32'(last_error), 32'(PD_ERR_SEQ), "last_error after lone DATA1");

		// Short DATA0, then a clean exchange
		new_block();
		send_first_half(`PD_PAYLOAD_BYTES - 1);
		await_pulse(SEL_PERR, 3, "p_error");
		check_value(32'(last_error), 32'(PD_ERR_LENGTH), "last_error after short DATA0");
		send_hash_block();
		await_ready(1'b1);
		check_value(digest, fold_block(), "digest after short DATA0");
		send_packet(`PD_PID_IN);
		await_pulse(SEL_START, 2, "transmit_start");

		// INTERRUPT drops a finished digest
		new_block();
		send_hash_block();
		await_ready(1'b1);
		send_packet(`PD_PID_OUT);
		pkt_q.push_back(`PD_TYPE_INTERRUPT);
		send_packet(`PD_PID_DATA0);
		await_ready(1'b0);
		send_packet(`PD_PID_IN);
		await_pulse(SEL_EMPTY, 2, "transmit_empty");
		check_value(n_start, 32'd2, "transmit_start count after INTERRUPT");

		// Second block while a digest is held
		new_block();
		send_hash_block();
		await_ready(1'b1);
		held = fold_block();
		check_value(digest, held, "first digest");
		new_block();
		send_hash_block();
		await_pulse(SEL_HERR, 1, "host_error");
		check_value(digest, held, "held digest");
		check_value(32'(digest_ready), 32'd1, "digest_ready while held");
		send_packet(`PD_PID_IN);
		await_pulse(SEL_START, 3, "transmit_start");

		$display("Summary: %0d mismatches, %0d assertion failures, %0d timeouts",
			errors, i_dut.u_sva.fail_count, timeouts);
		if (errors + i_dut.u_sva.fail_count + timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/pd_controller_sva.sv */
// ##########################################################
// Concurrent checks on IN responses, error codes, digest
// hold and one-cycle pulses, bound into pd_top
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

module pd_controller_sva (
	input wire logic             clk,
	input wire logic             n_rst,
	input wire logic             byte_valid,
	input wire pd_pkg::pd_byte_t rx_item,
	input wire logic             abort,
	input wire logic             take,
	input wire logic             block_valid,
	input wire logic             transmit_start,
	input wire logic             transmit_empty,
	input wire logic             p_error,
	input wire logic             host_error,
	input wire pd_pkg::pd_err_e  last_error,
	input wire logic             digest_ready,
	input wire logic [31:0]      digest
);
	timeunit 1ns;
	timeprecision 100ps;

	import pd_pkg::*;

	int   fail_count = 0;
	logic is_in;
	logic is_unknown;

	assign is_in      = byte_valid && rx_item.first && rx_item.data == `PD_PID_IN;
	assign is_unknown = byte_valid && rx_item.first && !(rx_item.data inside
		{`PD_PID_OUT, `PD_PID_IN, `PD_PID_DATA0, `PD_PID_DATA1});

	assert property (@(posedge clk) disable iff (!n_rst)
		is_in && !digest_ready |=> transmit_empty && !transmit_start)
	else begin
		$error("IN with no digest was not answered by transmit_empty alone");
		fail_count++;
	end

	// Answer and consume in one go
	assert property (@(posedge clk) disable iff (!n_rst)
		is_in && digest_ready |=> transmit_start && take && !transmit_empty ##1 !digest_ready)
	else begin
		$error("IN with a digest did not start a transmit and free the digest");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		is_unknown |=> p_error && last_error == PD_ERR_PID)
	else begin
		$error("Unknown PID did not raise p_error with a bad PID code");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		p_error |-> last_error != PD_ERR_NONE && (last_error != PD_ERR_LENGTH || abort))
	else begin
		$error("p_error with no reason, or a length error without abort");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		block_valid && digest_ready |=> host_error)
	else begin
		$error("Block arriving on a held digest did not raise host_error");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		digest_ready && !take && !abort |=> digest_ready && $stable(digest))
	else begin
		$error("Held digest changed or was released without take or abort");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		!((transmit_start || transmit_empty) && $past(transmit_start || transmit_empty)) &&
		!(p_error && $past(p_error)) && !(host_error && $past(host_error)))
	else begin
		$error("A response or error pulse lasted more than one cycle");
		fail_count++;
	end

endmodule

bind pd_top pd_controller_sva u_sva (
	.clk            (clk),
	.n_rst          (n_rst),
	.byte_valid     (byte_valid),
	.rx_item        (rx_item),
	.abort          (abort),
	.take           (take),
	.block_valid    (block_valid),
	.transmit_start (transmit_start),
	.transmit_empty (transmit_empty),
	.p_error        (p_error),
	.host_error     (host_error),
	.last_error     (last_error),
	.digest_ready   (digest_ready),
	.digest         (digest)
);

`default_nettype wire

/* hdl/pd_top.sv */
// ##########################################################
// Packet decoder top: framer, controller, block buffer
// and digest stage in pipeline order
// ##########################################################
`default_nettype none

module pd_top (
	input  wire logic       clk,
	input  wire logic       n_rst,
	input  wire logic       rx_strobe,
	input  wire logic [7:0] rx_byte,
	input  wire logic       rx_eop,
	output logic            transmit_start,
	output logic            transmit_empty,
	output logic            p_error,
	output logic            host_error,
	output pd_pkg::pd_err_e last_error,
	output logic            digest_ready,
	output logic [31:0]     digest
);

	import pd_pkg::*;

	logic        byte_valid;
	pd_byte_t    rx_item;
	logic        payload_valid;
	pd_payload_t payload;
	logic        abort;
	logic        take;
	logic        block_valid;
	pd_block_t   block;

	pd_byte_framer u_framer (
		.clk        (clk),
		.n_rst      (n_rst),
		.rx_strobe  (rx_strobe),
		.rx_byte    (rx_byte),
		.rx_eop     (rx_eop),
		.byte_valid (byte_valid),
		.rx_item    (rx_item)
	);

	pd_controller u_controller (
		.clk            (clk),
		.n_rst          (n_rst),
		.byte_valid     (byte_valid),
		.rx_item        (rx_item),
		.digest_ready   (digest_ready),
		.payload_valid  (payload_valid),
		.payload        (payload),
		.abort          (abort),
		.take           (take),
		.transmit_start (transmit_start),
		.transmit_empty (transmit_empty),
		.p_error        (p_error),
		.last_error     (last_error)
	);

	pd_block_buffer u_buffer (
		.clk           (clk),
		.n_rst         (n_rst),
		.payload_valid (payload_valid),
		.payload       (payload),
		.abort         (abort),
		.block_valid   (block_valid),
		.block         (block)
	);

	pd_block_digest u_digest (
		.clk          (clk),
		.n_rst        (n_rst),
		.block_valid  (block_valid),
		.block        (block),
		.abort        (abort),
		.take         (take),
		.digest_ready (digest_ready),
		.digest       (digest),
		.host_error   (host_error)
	);

endmodule

`default_nettype wire

/* hdl/pd_block_digest.sv */
// ##########################################################
// Block digest: folds a block word by word into a 32-bit
// digest and holds it until taken or aborted
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

module pd_block_digest (
	input  wire logic              clk,
	input  wire logic              n_rst,
	input  wire logic              block_valid,
	input  wire pd_pkg::pd_block_t block,
	input  wire logic              abort,
	input  wire logic              take,
	output logic                   digest_ready,
	output logic [31:0]            digest,
	output logic                   host_error
);

	import pd_pkg::*;

	localparam int CW = $clog2(`PD_BLOCK_WORDS);

	typedef enum logic [1:0] {
		DG_FREE,
		DG_BUSY,
		DG_READY
	} dg_state_e;

	dg_state_e     state;
	logic [CW-1:0] word_idx;
	pd_block_t     blk_q;
	logic [31:0]   mixed;

	// Current word XORed in before the rotate
	assign mixed = digest ^ blk_q[word_idx];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state      <= DG_FREE;
			word_idx   <= '0;
			digest     <= `PD_DIGEST_SEED;
			host_error <= 1'b0;
		end else begin
			// Blocks are dropped while busy or holding a digest
			host_error <= block_valid && (state != DG_FREE);
			if (abort) begin
				state <= DG_FREE;
			end else begin
				case (state)
					DG_FREE: begin
						if (block_valid) begin
							state    <= DG_BUSY;
							word_idx <= '0;
							digest   <= `PD_DIGEST_SEED;
						end
					end
					DG_BUSY: begin
						digest   <= (mixed << `PD_DIGEST_ROT) |
						            (mixed >> (32 - `PD_DIGEST_ROT));
						word_idx <= word_idx + CW'(1);
						if (word_idx == CW'(`PD_BLOCK_WORDS - 1)) begin
							state <= DG_READY;
						end
					end
					DG_READY: begin
						if (take) begin
							state <= DG_FREE;
						end
					end
					default: begin
						state <= DG_FREE;
					end
				endcase
			end
		end
	end

	// Private copy so the buffer can refill during the fold
	always_ff @(posedge clk) begin
		if (block_valid && state == DG_FREE) begin
			blk_q <= block;
		end
	end

	assign digest_ready = (state == DG_READY);

endmodule

`default_nettype wire

/* hdl/pd_block_buffer.sv */
// ##########################################################
// Block buffer: writes payload bytes into their slots and
// releases the block once every slot has been written
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

module pd_block_buffer (
	input  wire logic                clk,
	input  wire logic                n_rst,
	input  wire logic                payload_valid,
	input  wire pd_pkg::pd_payload_t payload,
	input  wire logic                abort,
	output logic                     block_valid,
	output pd_pkg::pd_block_t        block
);

	localparam int SLOTS = `PD_BLOCK_WORDS * 4;

	// One bit per written byte slot
	logic [SLOTS-1:0] mask;
	logic [SLOTS-1:0] mask_n;
	// Bit offset of the byte in its word, slot 0 is the top byte
	logic [4:0]       byte_sh;

	assign mask_n  = mask | (SLOTS'(1) << payload.slot);
	assign byte_sh = {~payload.slot[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (payload_valid) begin
			block[payload.slot[3:2]][byte_sh +: 8] <= payload.data;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			mask        <= '0;
			block_valid <= 1'b0;
		end else begin
			block_valid <= 1'b0;
			if (abort) begin
				mask <= '0;
			end else if (payload_valid) begin
				if (payload.is_final) begin
					// Only a complete block goes on to the digest
					block_valid <= &mask_n;
					mask        <= '0;
				end else begin
					mask <= mask_n;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pd_controller.sv */
// ##########################################################
// Decoder controller: PID state machine that steers payload
// bytes, raises protocol errors and answers IN tokens
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

module pd_controller (
	input  wire logic             clk,
	input  wire logic             n_rst,
	input  wire logic             byte_valid,
	input  wire pd_pkg::pd_byte_t rx_item,
	input  wire logic             digest_ready,
	output logic                  payload_valid,
	output pd_pkg::pd_payload_t   payload,
	output logic                  abort,
	output logic                  take,
	output logic                  transmit_start,
	output logic                  transmit_empty,
	output logic                  p_error,
	output pd_pkg::pd_err_e       last_error
);

	import pd_pkg::*;

	// Index of the last payload byte in DATA0 and DATA1
	localparam logic [5:0] D0_END = 6'(`PD_PAYLOAD_BYTES + 1);
	localparam logic [5:0] D1_END = 6'(`PD_PAYLOAD_BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_AFTER_OUT,
		ST_D0_TYPE,
		ST_D0_PAY,
		ST_EXP_D1,
		ST_D1_PAY,
		ST_DRAIN
	} state_e;

	state_e      state;
	state_e      state_n;
	// First half of a block sits in the buffer
	logic        half_q;
	logic        half_n;
	logic        pv_n;
	logic        abort_n;
	logic        start_n;
	logic        empty_n;
	logic        err_n;
	logic        at_end;
	pd_err_e     err_code;
	pd_payload_t payload_n;
	logic [5:0]  slot_d0;
	logic [5:0]  slot_d1;

	// DATA0 payload starts at index 2, DATA1 payload at index 1
	assign slot_d0 = rx_item.index - 6'd2;
	assign slot_d1 = rx_item.index + 6'(`PD_PAYLOAD_BYTES - 1);

	always_comb begin
		state_n   = state;
		half_n    = half_q;
		pv_n      = 1'b0;
		abort_n   = 1'b0;
		start_n   = 1'b0;
		empty_n   = 1'b0;
		err_n     = 1'b0;
		at_end    = 1'b0;
		err_code  = PD_ERR_NONE;
		payload_n = '{data: rx_item.data, slot: '0, is_final: 1'b0};

		if (byte_valid) begin
			case (state)
				ST_IDLE, ST_AFTER_OUT, ST_EXP_D1: begin
					// Trailing bytes of token packets are ignored here
					if (rx_item.first) begin
						case (rx_item.data)
							`PD_PID_OUT: begin
								state_n = half_q ? ST_EXP_D1 : ST_AFTER_OUT;
							end
							`PD_PID_IN: begin
								start_n = digest_ready;
								empty_n = !digest_ready;
								state_n = ST_IDLE;
							end
							`PD_PID_DATA0: begin
								if (state == ST_IDLE) begin
									err_n    = 1'b1;
									err_code = PD_ERR_SEQ;
								end else if (rx_item.last) begin
									err_n    = 1'b1;
									err_code = PD_ERR_LENGTH;
									abort_n  = 1'b1;
								end else begin
									state_n = ST_D0_TYPE;
								end
							end
							`PD_PID_DATA1: begin
								// Needs both an OUT and a held HASH half
								if (state != ST_EXP_D1) begin
									err_n    = 1'b1;
									err_code = PD_ERR_SEQ;
								end else if (rx_item.last) begin
									err_n    = 1'b1;
									err_code = PD_ERR_LENGTH;
									abort_n  = 1'b1;
								end else begin
									state_n = ST_D1_PAY;
								end
							end
							default: begin
								err_n    = 1'b1;
								err_code = PD_ERR_PID;
							end
						endcase
						if (err_n) begin
							state_n = rx_item.last ? ST_IDLE : ST_DRAIN;
						end
					end
				end

				ST_D0_TYPE: begin
					if (rx_item.data == `PD_TYPE_INTERRUPT) begin
						abort_n = 1'b1;
						state_n = rx_item.last ? ST_IDLE : ST_DRAIN;
					end else if (rx_item.data == `PD_TYPE_HASH && !rx_item.last) begin
						// A new first half replaces any held one
						half_n  = 1'b0;
						state_n = ST_D0_PAY;
					end else begin
						err_n = 1'b1;
						if (rx_item.data == `PD_TYPE_HASH) begin
							err_code = PD_ERR_LENGTH;
							abort_n  = 1'b1;
						end else begin
							// Unknown type code
							err_code = PD_ERR_PID;
						end
						state_n = rx_item.last ? ST_IDLE : ST_DRAIN;
					end
				end

				ST_D0_PAY, ST_D1_PAY: begin
					pv_n = 1'b1;
					if (state == ST_D0_PAY) begin
						payload_n.slot = slot_d0[3:0];
						at_end         = (rx_item.index == D0_END);
					end else begin
						payload_n.slot = slot_d1[3:0];
						at_end         = (rx_item.index == D1_END);
					end
					payload_n.is_final = (state == ST_D1_PAY) && at_end && rx_item.last;

					if (at_end && rx_item.last) begin
						half_n  = (state == ST_D0_PAY);
						state_n = ST_IDLE;
					end else if (at_end || rx_item.last) begin
						// Packet ends early or runs past its payload
						err_n    = 1'b1;
						err_code = PD_ERR_LENGTH;
						abort_n  = 1'b1;
						state_n  = rx_item.last ? ST_IDLE : ST_DRAIN;
					end
				end

				ST_DRAIN: begin
					if (rx_item.last) begin
						state_n = ST_IDLE;
					end
				end

				default: begin
					state_n = ST_IDLE;
				end
			endcase
		end

		// Abort always drops the half-built block
		if (abort_n) begin
			half_n = 1'b0;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state          <= ST_IDLE;
			half_q         <= 1'b0;
			payload_valid  <= 1'b0;
			abort          <= 1'b0;
			take           <= 1'b0;
			transmit_start <= 1'b0;
			transmit_empty <= 1'b0;
			p_error        <= 1'b0;
			last_error     <= PD_ERR_NONE;
		end else begin
			state          <= state_n;
			half_q         <= half_n;
			payload_valid  <= pv_n;
			abort          <= abort_n;
			take           <= start_n;
			transmit_start <= start_n;
			transmit_empty <= empty_n;
			p_error        <= err_n;
			if (err_n) begin
				last_error <= err_code;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pv_n) begin
			payload <= payload_n;
		end
	end

endmodule

`default_nettype wire

/* hdl/pd_byte_framer.sv */
// ##########################################################
// Byte framer: registers received bytes and tags each one
// with its index in the packet and first/last flags
// ##########################################################
`default_nettype none

module pd_byte_framer (
	input  wire logic       clk,
	input  wire logic       n_rst,
	input  wire logic       rx_strobe,
	input  wire logic [7:0] rx_byte,
	input  wire logic       rx_eop,
	output logic            byte_valid,
	output pd_pkg::pd_byte_t rx_item
);

	// Index of the next byte within the current packet
	logic [5:0] count;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			count      <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= rx_strobe;
			if (rx_strobe) begin
				if (rx_eop) begin
					count <= '0;
				end else if (count != '1) begin
					// Saturate so an overlong packet still reads as too long
					count <= count + 6'd1;
				end
			end
		end
	end

	// Tagged byte, captured with each strobe
	always_ff @(posedge clk) begin
		if (rx_strobe) begin
			rx_item.data  <= rx_byte;
			rx_item.index <= count;
			rx_item.first <= (count == '0);
			rx_item.last  <= rx_eop;
		end
	end

endmodule

`default_nettype wire

/* hdl/pd_pkg.sv */
// ##########################################################
// Packet decoder package: received byte, payload command,
// block and error-code types
// ##########################################################
`default_nettype none

`include "pd_consts.svh"

package pd_pkg;

	// One received byte as tagged by the framer
	typedef struct packed {
		logic [7:0] data;
		logic [5:0] index;
		logic       first;
		logic       last;
	} pd_byte_t;

	// Payload byte steered into the block buffer
	typedef struct packed {
		logic [7:0] data;
		// Byte slot within the block
		logic [3:0] slot;
		// Set on the byte that completes the block
		logic       is_final;
	} pd_payload_t;

	// Word i is blk[i], byte slot 0 sits in bits [31:24] of word 0
	typedef logic [`PD_BLOCK_WORDS-1:0][31:0] pd_block_t;

	// Reason of the most recent protocol error
	typedef enum logic [1:0] {
		PD_ERR_NONE   = 2'd0,
		PD_ERR_PID    = 2'd1,
		PD_ERR_LENGTH = 2'd2,
		PD_ERR_SEQ    = 2'd3
	} pd_err_e;

endpackage

`default_nettype wire

/* hdl/pd_consts.svh */
// ##########################################################
// Packet decoder constants: PID and data-type codes,
// payload and block sizes, digest seed and rotation
// ##########################################################
`ifndef PD_CONSTS_SVH
`define PD_CONSTS_SVH

// Token and data PIDs
`define PD_PID_OUT        8'hE1
`define PD_PID_IN         8'h69
`define PD_PID_DATA0      8'hC3
`define PD_PID_DATA1      8'h4B

// Type byte carried by DATA0
`define PD_TYPE_INTERRUPT 8'h01
`define PD_TYPE_HASH      8'h02

// Sizes
`define PD_PAYLOAD_BYTES  8
`define PD_BLOCK_WORDS    4

// Digest fold
`define PD_DIGEST_SEED    32'h811C9DC5
`define PD_DIGEST_ROT     5

`endif
